// ==== vlog.f ====
design/cpu_pkg.sv
design/cpu_ctrl_if.sv
design/controller.sv
design/reg_file.sv
design/alu.sv
design/memory.sv
design/cpu_top.sv
bench/tb_cpu.sv

// ==== Makefile ====
# Verilator build and run of the CPU testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check run.log for the pass line"
	@echo "  clean  remove the build directory and run.log"

test:
	verilator --binary --timing --assert -f vlog.f --top-module tb_cpu -Mdir obj_dir -o sim
	./obj_dir/sim | tee run.log
	grep -q "Verification passed" run.log

clean:
	rm -rf obj_dir run.log

// ==== bench/tb_cpu.sv ====
module tb_cpu;

  localparam int MEM_WORDS   = 256;
  localparam int TOTAL_INSTR = 704;  // Words loaded over all tests
  localparam int MAX_CYCLES  = 7 * TOTAL_INSTR * 4;

  localparam cpu_pkg::word_t NOP_INSTR = 16'h0000;
  localparam cpu_pkg::word_t HLT_INSTR = 16'h0f00;

  logic           clk;
  logic           rst_n;
  logic           load_en;
  cpu_pkg::word_t load_addr;
  cpu_pkg::word_t load_data;
  logic           out_valid;
  cpu_pkg::word_t out_data;
  logic           halted;

  cpu_pkg::word_t prog[$];
  cpu_pkg::word_t expect_q[$];
  cpu_pkg::word_t outs[$];
  int             cycles = 0;
  integer         seed;

  cpu_top #(.MEM_WORDS(MEM_WORDS)) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .out_valid (out_valid),
    .out_data  (out_data),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout: the CPU did not halt within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $fatal(1);
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input cpu_pkg::word_t exp,
                            input cpu_pkg::word_t act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: expected halted %b, actual %b", name, exp, act));
    end
  endtask

  function automatic cpu_pkg::word_t pack_instr(input logic [3:0] op, input logic [3:0] funct,
                                                input logic [3:0] dst, input logic [3:0] src);
    return {op, funct, dst, src};
  endfunction

  // LLI, LUI and JAL carry a byte in the low half
  function automatic cpu_pkg::word_t byte_instr(input logic [3:0] op, input logic [3:0] r,
                                                input logic [7:0] b);
    return {op, r, b};
  endfunction

  function automatic cpu_pkg::word_t alu_instr(input logic [3:0] op, input logic imm,
                                               input logic ind, input logic [3:0] dst,
                                               input logic [3:0] src);
    return {2'b01, op, imm, ind, dst, src};  // Opcodes 4 to 7
  endfunction

  function automatic cpu_pkg::word_t out_instr(input logic [3:0] r);
    return pack_instr(cpu_pkg::OP_SYS, 4'h2, r, 4'h0);
  endfunction

  function automatic cpu_pkg::word_t expected_alu(input logic [3:0] op, input cpu_pkg::word_t a,
                                                  input cpu_pkg::word_t b);
    case (op)
      4'd0: return a + b;
      4'd1: return a - b;
      4'd2: return a & b;
      4'd3: return a | b;
      4'd4: return a ^ b;
      4'd5: return {a[14:0], 1'b0};
      4'd6: return {1'b0, a[15:1]};
      default: return b;
    endcase
  endfunction

  // Condition 2k tests flag k set, 2k+1 tests it clear
  function automatic logic branch_taken(input int cond, input cpu_pkg::word_t a,
                                        input cpu_pkg::word_t b);
    cpu_pkg::word_t diff;
    int             sdiff;
    logic           flag;
    diff  = a - b;
    sdiff = int'($signed(a)) - int'($signed(b));
    case (cond / 2)
      0: flag = (diff == 16'h0000);
      1: flag = diff[15];
      2: flag = (a < b);  // Borrow
      default: flag = (sdiff > 32767) || (sdiff < -32768);  // Signed result out of range
    endcase
    return (cond % 2 == 1) ? !flag : flag;
  endfunction

  task automatic set_reg(input logic [3:0] r, input cpu_pkg::word_t value);
    prog.push_back(byte_instr(cpu_pkg::OP_LLI, r, value[7:0]));
    prog.push_back(byte_instr(cpu_pkg::OP_LUI, r, value[15:8]));
  endtask

  // Load under reset, run to HLT, then watch 50 more cycles
  task automatic run_program(input string name);
    rst_n = 1'b0;
    foreach (prog[i]) begin
      @(negedge clk);
      load_en   = 1'b1;
      load_addr = cpu_pkg::word_t'(i);
      load_data = prog[i];
    end
    @(negedge clk);
    load_en = 1'b0;
    repeat (3) @(negedge clk);
    check_flag(name, 1'b0, halted);
    rst_n = 1'b1;
    outs.delete();
    do begin
      @(negedge clk);
      if (out_valid) outs.push_back(out_data);
    end while (!halted);
    repeat (50) begin
      @(negedge clk);
      if (out_valid) outs.push_back(out_data);
    end
    check_flag(name, 1'b1, halted);
    if (outs.size() != expect_q.size()) begin
      abort_run($sformatf("%s: %0d words came out where %0d were expected",
                          name, outs.size(), expect_q.size()));
    end
    foreach (expect_q[i]) check_word(name, expect_q[i], outs[i]);
    prog.delete();
    expect_q.delete();
  endtask

  task automatic test_constants();
    set_reg(4'd5, 16'h1234);
    prog.push_back(out_instr(4'd5));
    prog.push_back(NOP_INSTR);
    set_reg(4'd6, 16'hcdab);
    prog.push_back(out_instr(4'd6));
    prog.push_back(byte_instr(cpu_pkg::OP_LLI, 4'd5, 8'h77));  // High byte stays
    prog.push_back(out_instr(4'd5));
    set_reg(4'd7, 16'h00c0);
    prog.push_back(pack_instr(cpu_pkg::OP_MEM, 4'h3, 4'd6, 4'd7));  // r6 to mem[0xc0]
    prog.push_back(pack_instr(cpu_pkg::OP_SYS, 4'h3, 4'd7, 4'h0));  // OUT indirect
    prog.push_back(HLT_INSTR);
    expect_q.push_back(16'h1234);
    expect_q.push_back(16'hcdab);
    expect_q.push_back(16'h1277);
    expect_q.push_back(16'hcdab);
    run_program("constants");
  endtask

  task automatic test_alu();
    cpu_pkg::word_t a;
    cpu_pkg::word_t b;
    for (int op = 0; op < 8; op++) begin
      a = cpu_pkg::word_t'($random(seed));
      b = cpu_pkg::word_t'($random(seed));
      set_reg(4'd5, a);
      set_reg(4'd6, b);
      prog.push_back(alu_instr(op[3:0], 1'b0, 1'b0, 4'd5, 4'd6));
      prog.push_back(out_instr(4'd5));
      expect_q.push_back(expected_alu(op[3:0], a, b));
      a = cpu_pkg::word_t'($random(seed));
      b = cpu_pkg::word_t'($random(seed)) & 16'h000f;  // Immediate is the src field
      set_reg(4'd5, a);
      prog.push_back(alu_instr(op[3:0], 1'b1, 1'b0, 4'd5, b[3:0]));
      prog.push_back(out_instr(4'd5));
      expect_q.push_back(expected_alu(op[3:0], a, b));
      a = cpu_pkg::word_t'($random(seed));
      b = cpu_pkg::word_t'($random(seed));
      set_reg(4'd5, a);
      set_reg(4'd6, b);
      set_reg(4'd7, 16'h00f0);
      prog.push_back(pack_instr(cpu_pkg::OP_MEM, 4'h3, 4'd6, 4'd7));  // Operand to mem[0xf0]
      prog.push_back(alu_instr(op[3:0], 1'b0, 1'b1, 4'd5, 4'd7));
      prog.push_back(out_instr(4'd5));
      expect_q.push_back(expected_alu(op[3:0], a, b));
      prog.push_back(HLT_INSTR);
      run_program($sformatf("alu op %0d", op));
    end
  endtask

  task automatic test_moves();
    set_reg(4'd5, 16'h1357);
    prog.push_back(pack_instr(cpu_pkg::OP_MEM, 4'h0, 4'd6, 4'd5));  // LD r6 from r5
    prog.push_back(out_instr(4'd6));
    prog.push_back(pack_instr(cpu_pkg::OP_MEM, 4'h1, 4'd5, 4'd7));  // ST r5 into r7
    prog.push_back(out_instr(4'd7));
    set_reg(4'd8, 16'h00a0);
    set_reg(4'd9, 16'h2468);
    prog.push_back(pack_instr(cpu_pkg::OP_MEM, 4'h3, 4'd9, 4'd8));
    prog.push_back(pack_instr(cpu_pkg::OP_MEM, 4'h2, 4'd10, 4'd8));
    prog.push_back(out_instr(4'd10));
    prog.push_back(HLT_INSTR);
    expect_q.push_back(16'h1357);
    expect_q.push_back(16'h1357);
    expect_q.push_back(16'h2468);
    run_program("moves");
  endtask

  task automatic test_branches();
    cpu_pkg::word_t lhs[4];
    cpu_pkg::word_t rhs[4];
    lhs = '{16'h0005, 16'h0005, 16'h0003, 16'h8000};
    rhs = '{16'h0005, 16'h0003, 16'h0005, 16'h0001};
    for (int cond = 0; cond < 8; cond++) begin
      for (int p = 0; p < 4; p++) begin
        set_reg(4'd5, lhs[p]);
        set_reg(4'd6, rhs[p]);
        set_reg(cpu_pkg::REG_BA, 16'd13);
        set_reg(4'd8, 16'hf000 | cpu_pkg::word_t'(cond));
        set_reg(4'd9, 16'hc000 | cpu_pkg::word_t'(cond));
        prog.push_back(pack_instr(cpu_pkg::OP_BR, cond[3:0], 4'd5, 4'd6));
        prog.push_back(out_instr(4'd8));
        prog.push_back(HLT_INSTR);
        prog.push_back(out_instr(4'd9));  // Address 13
        prog.push_back(HLT_INSTR);
        if (branch_taken(cond, lhs[p], rhs[p])) begin
          expect_q.push_back(16'hc000 | cpu_pkg::word_t'(cond));
        end else begin
          expect_q.push_back(16'hf000 | cpu_pkg::word_t'(cond));
        end
        run_program($sformatf("br cond %0d pair %0d", cond, p));
      end
    end
  endtask

  task automatic test_jal_stack();
    set_reg(4'd5, 16'h0008);
    prog.push_back(byte_instr(cpu_pkg::OP_JAL, 4'd5, 8'h04));  // Target 12
    repeat (9) prog.push_back(out_instr(4'd5));
    prog.push_back(out_instr(cpu_pkg::REG_RA));
    set_reg(4'd6, 16'h1111);
    set_reg(4'd7, 16'h2222);
    set_reg(4'd8, 16'h3333);
    prog.push_back(pack_instr(cpu_pkg::OP_STK, 4'h0, 4'd6, 4'h0));
    prog.push_back(pack_instr(cpu_pkg::OP_STK, 4'h0, 4'd7, 4'h0));
    prog.push_back(pack_instr(cpu_pkg::OP_STK, 4'h0, 4'd8, 4'h0));
    prog.push_back(pack_instr(cpu_pkg::OP_STK, 4'h1, 4'd9, 4'h0));
    prog.push_back(pack_instr(cpu_pkg::OP_STK, 4'h1, 4'd10, 4'h0));
    prog.push_back(pack_instr(cpu_pkg::OP_STK, 4'h1, 4'd11, 4'h0));
    prog.push_back(out_instr(4'd9));
    prog.push_back(out_instr(4'd10));
    prog.push_back(out_instr(4'd11));
    prog.push_back(out_instr(cpu_pkg::REG_SP));
    prog.push_back(HLT_INSTR);
    expect_q.push_back(16'h0003);  // Return address after JAL
    expect_q.push_back(16'h3333);
    expect_q.push_back(16'h2222);
    expect_q.push_back(16'h1111);
    expect_q.push_back(cpu_pkg::word_t'(MEM_WORDS - 1));
    run_program("jal and stack");
  endtask

  task automatic test_halt();
    set_reg(4'd5, 16'h00aa);
    prog.push_back(out_instr(4'd5));
    prog.push_back(HLT_INSTR);
    prog.push_back(out_instr(4'd5));
    prog.push_back(NOP_INSTR);
    expect_q.push_back(16'h00aa);
    run_program("halt");
  endtask

  initial begin
    seed      = 32'hc80c_ed7d;
    rst_n     = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    test_constants();
    test_alu();
    test_moves();
    test_branches();
    test_jal_stack();
    test_halt();
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== design/cpu_top.sv ====
module cpu_top #(
  parameter int MEM_WORDS = 256
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           load_en,
  input  cpu_pkg::word_t load_addr,
  input  cpu_pkg::word_t load_data,
  output logic           out_valid,
  output cpu_pkg::word_t out_data,
  output logic           halted
);

  cpu_ctrl_if ctl_if ();

  cpu_pkg::word_t  bus;
  cpu_pkg::word_t  reg_bus;
  cpu_pkg::word_t  opnd_a;
  cpu_pkg::word_t  alu_result;
  cpu_pkg::word_t  mem_data;
  cpu_pkg::flags_t flags;

  controller ctrl_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .bus    (bus),
    .flags  (flags),
    .ctl    (ctl_if),
    .halted (halted)
  );

  reg_file #(.MEM_WORDS(MEM_WORDS)) regs_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus     (bus),
    .ctl     (ctl_if),
    .reg_bus (reg_bus),
    .opnd_a  (opnd_a)
  );

  // Second operand is reg[src_sel] straight from the register file
  alu alu_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctl    (ctl_if),
    .opnd_a (opnd_a),
    .opnd_b (reg_bus),
    .result (alu_result),
    .flags  (flags)
  );

  memory #(.MEM_WORDS(MEM_WORDS)) mem_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctl       (ctl_if),
    .bus       (bus),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .rd_data   (mem_data)
  );

  always_comb begin
    bus = '0;  // Idle bus reads as zero
    if (ctl_if.reg_out_en) begin
      bus = reg_bus;
    end else if (ctl_if.alu_out_en) begin
      bus = alu_result;
    end else if (ctl_if.mem_out_en) begin
      bus = mem_data;
    end else if (ctl_if.ctl_out_en) begin
      bus = ctl_if.ctl_data;
    end
  end

  assign out_valid = ctl_if.dsp_in_en;
  assign out_data  = bus;

  one_bus_driver: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({ctl_if.reg_out_en, ctl_if.alu_out_en, ctl_if.mem_out_en, ctl_if.ctl_out_en}));

endmodule

// ==== design/memory.sv ====
module memory #(
  parameter int MEM_WORDS = 256
) (
  input  logic           clk,
  input  logic           rst_n,
  cpu_ctrl_if.dp         ctl,
  input  cpu_pkg::word_t bus,
  input  logic           load_en,
  input  cpu_pkg::word_t load_addr,
  input  cpu_pkg::word_t load_data,
  output cpu_pkg::word_t rd_data
);

  localparam int AW = $clog2(MEM_WORDS);

  cpu_pkg::word_t mem [MEM_WORDS];
  logic [AW-1:0]  addr_q;

  always_ff @(posedge clk) begin
    if (ctl.mem_addr_en) begin
      addr_q <= AW'(bus % MEM_WORDS);
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[AW'(load_addr % MEM_WORDS)] <= load_data;  // Program load
    end else if (ctl.mem_in_en) begin
      mem[addr_q] <= bus;
    end
  end

  assign rd_data = mem[addr_q];

  load_in_reset: assert property (@(posedge clk) load_en |-> !rst_n);

endmodule

// ==== design/alu.sv ====
module alu (
  input  logic            clk,
  input  logic            rst_n,
  cpu_ctrl_if.dp          ctl,
  input  cpu_pkg::word_t  opnd_a,
  input  cpu_pkg::word_t  opnd_b,
  output cpu_pkg::word_t  result,
  output cpu_pkg::flags_t flags
);

  logic [16:0] wide;  // Bit 16 is carry or borrow
  logic        ovf;

  always_comb begin
    wide = {1'b0, opnd_b};
    ovf  = 1'b0;
    case (ctl.alu_op)
      cpu_pkg::ALU_ADD: begin
        wide = {1'b0, opnd_a} + {1'b0, opnd_b};
        ovf  = (opnd_a[15] == opnd_b[15]) && (wide[15] != opnd_a[15]);
      end
      cpu_pkg::ALU_SUB: begin
        wide = {1'b0, opnd_a} - {1'b0, opnd_b};
        ovf  = (opnd_a[15] != opnd_b[15]) && (wide[15] != opnd_a[15]);
      end
      cpu_pkg::ALU_AND: wide = {1'b0, opnd_a & opnd_b};
      cpu_pkg::ALU_OR:  wide = {1'b0, opnd_a | opnd_b};
      cpu_pkg::ALU_XOR: wide = {1'b0, opnd_a ^ opnd_b};
      cpu_pkg::ALU_SHL: wide = {opnd_a, 1'b0};
      cpu_pkg::ALU_SHR: wide = {opnd_a[0], 1'b0, opnd_a[15:1]};  // Shifted-out bit to carry
      default: begin
      end
    endcase
  end

  assign result = wide[15:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (ctl.alu_out_en) begin
      flags <= {ovf, wide[16], wide[15], wide[15:0] == 16'h0000};
    end
  end

endmodule

// ==== design/reg_file.sv ====
module reg_file #(
  parameter int MEM_WORDS = 256
) (
  input  logic           clk,
  input  logic           rst_n,
  input  cpu_pkg::word_t bus,
  cpu_ctrl_if.dp         ctl,
  output cpu_pkg::word_t reg_bus,
  output cpu_pkg::word_t opnd_a
);

  cpu_pkg::word_t regs [16];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      regs[cpu_pkg::REG_PC] <= '0;
      regs[cpu_pkg::REG_SP] <= cpu_pkg::word_t'(MEM_WORDS - 1);  // Top of memory
    end else begin
      if (ctl.reg_in_en) begin
        regs[ctl.dst_sel] <= bus;
      end
      if (ctl.reg_lo_en) begin
        regs[ctl.dst_sel][7:0] <= bus[7:0];
      end
      if (ctl.reg_up_en) begin
        regs[ctl.dst_sel][15:8] <= bus[7:0];  // LUI byte arrives in bus low half
      end
      if (ctl.reg_pc_inc) begin
        regs[cpu_pkg::REG_PC] <= regs[cpu_pkg::REG_PC] + 16'd1;
      end
      if (ctl.reg_sp_inc) begin
        regs[cpu_pkg::REG_SP] <= regs[cpu_pkg::REG_SP] + 16'd1;
      end else if (ctl.reg_sp_dec) begin
        regs[cpu_pkg::REG_SP] <= regs[cpu_pkg::REG_SP] - 16'd1;
      end
    end
  end

  assign reg_bus = regs[ctl.src_sel];
  assign opnd_a  = regs[ctl.dst_sel];

  sp_one_way: assert property (@(posedge clk) disable iff (!rst_n)
    !(ctl.reg_sp_inc && ctl.reg_sp_dec));

endmodule

// ==== design/controller.sv ====
module controller (
  input  logic            clk,
  input  logic            rst_n,
  input  cpu_pkg::word_t  bus,
  input  cpu_pkg::flags_t flags,
  cpu_ctrl_if.ctrl        ctl,
  output logic            halted
);

  typedef enum logic {
    ST_RUN,
    ST_HALT
  } state_t;

  state_t            state_q;
  cpu_pkg::step_t    step_q;
  cpu_pkg::word_t    ir_q;
  cpu_pkg::opcode_t  opcode;
  logic [3:0]        funct;
  cpu_pkg::reg_sel_t dst;
  cpu_pkg::reg_sel_t src;
  logic              imm;
  logic              ind;
  logic              br_taken;
  logic              halt_set;

  assign opcode = cpu_pkg::opcode_t'(ir_q[15:12]);
  assign funct  = ir_q[11:8];
  assign dst    = ir_q[7:4];
  assign src    = ir_q[3:0];
  assign imm    = ir_q[9];
  assign ind    = ir_q[8];

  // Even funct branches on a set flag, odd on a clear one
  assign br_taken = !funct[3] && (flags[funct[2:1]] != funct[0]);
  assign halted   = (state_q == ST_HALT);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ST_RUN;
      step_q  <= '0;
    end else if (state_q == ST_RUN) begin
      step_q <= (step_q == cpu_pkg::LAST_STEP) ? '0 : step_q + 3'd1;
      if (halt_set) begin
        state_q <= ST_HALT;  // Step freezes at 4
      end
    end
  end

  always_ff @(posedge clk) begin
    if (step_q == 3'd2) begin
      ir_q <= bus;
    end
  end

  always_comb begin
    ctl.alu_op      = cpu_pkg::ALU_ADD;
    ctl.src_sel     = src;
    ctl.dst_sel     = dst;
    ctl.reg_out_en  = 1'b0;
    ctl.alu_out_en  = 1'b0;
    ctl.mem_out_en  = 1'b0;
    ctl.ctl_out_en  = 1'b0;
    ctl.ctl_data    = '0;
    ctl.mem_addr_en = 1'b0;
    ctl.mem_in_en   = 1'b0;
    ctl.reg_in_en   = 1'b0;
    ctl.reg_lo_en   = 1'b0;
    ctl.reg_up_en   = 1'b0;
    ctl.dsp_in_en   = 1'b0;
    ctl.reg_pc_inc  = 1'b0;
    ctl.reg_sp_inc  = 1'b0;
    ctl.reg_sp_dec  = 1'b0;
    halt_set        = 1'b0;

    case (step_q)
      3'd0: begin
        ctl.src_sel     = cpu_pkg::REG_PC;
        ctl.reg_out_en  = 1'b1;
        ctl.mem_addr_en = 1'b1;
      end
      3'd1: begin
        ctl.mem_out_en = 1'b1;
        ctl.reg_pc_inc = 1'b1;
      end
      3'd2: begin
        ctl.mem_out_en = 1'b1;  // IR captures here
      end
      default: begin
        case (opcode)
          cpu_pkg::OP_SYS: begin
            if (funct == 4'h2 || funct == 4'h3) begin  // OUT, funct 3 is indirect
              ctl.src_sel = dst;
              if (!ind) begin
                ctl.reg_out_en = (step_q == 3'd3);
                ctl.dsp_in_en  = (step_q == 3'd3);
              end else if (step_q == 3'd3) begin
                ctl.reg_out_en  = 1'b1;
                ctl.mem_addr_en = 1'b1;
              end else if (step_q == 3'd4) begin
                ctl.mem_out_en = 1'b1;
                ctl.dsp_in_en  = 1'b1;
              end
            end
            halt_set = (funct == 4'hf) && (step_q == 3'd3);
          end
          cpu_pkg::OP_LLI, cpu_pkg::OP_LUI: begin
            ctl.dst_sel  = funct;
            ctl.ctl_data = {8'h00, ir_q[7:0]};
            if (step_q == 3'd3) begin
              ctl.ctl_out_en = 1'b1;
              ctl.reg_lo_en  = (opcode == cpu_pkg::OP_LLI);
              ctl.reg_up_en  = (opcode == cpu_pkg::OP_LUI);
            end
          end
          cpu_pkg::OP_MEM: begin
            case (funct)
              4'h0: begin  // LD
                ctl.reg_out_en = (step_q == 3'd3);
                ctl.reg_in_en  = (step_q == 3'd3);
              end
              4'h1: begin  // ST, moves dst into src
                ctl.src_sel    = dst;
                ctl.dst_sel    = src;
                ctl.reg_out_en = (step_q == 3'd3);
                ctl.reg_in_en  = (step_q == 3'd3);
              end
              4'h2: begin  // LD*
                ctl.reg_out_en  = (step_q == 3'd3);
                ctl.mem_addr_en = (step_q == 3'd3);
                ctl.mem_out_en  = (step_q == 3'd4);
                ctl.reg_in_en   = (step_q == 3'd4);
              end
              4'h3: begin  // ST*
                if (step_q == 3'd4) begin
                  ctl.src_sel = dst;
                end
                ctl.reg_out_en  = (step_q == 3'd3) || (step_q == 3'd4);
                ctl.mem_addr_en = (step_q == 3'd3);
                ctl.mem_in_en   = (step_q == 3'd4);
              end
              default: begin
              end
            endcase
          end
          cpu_pkg::OP_ALU0, cpu_pkg::OP_ALU1, cpu_pkg::OP_ALU2, cpu_pkg::OP_ALU3: begin
            ctl.alu_op   = cpu_pkg::alu_op_t'(ir_q[13:10]);
            ctl.ctl_data = {12'h000, src};
            if (imm) begin
              if (step_q == 3'd3) begin
                ctl.dst_sel    = cpu_pkg::REG_RES;
                ctl.ctl_out_en = 1'b1;
                ctl.reg_in_en  = 1'b1;
              end else if (step_q == 3'd4) begin
                ctl.src_sel    = cpu_pkg::REG_RES;
                ctl.alu_out_en = 1'b1;
                ctl.reg_in_en  = 1'b1;
              end
            end else if (ind) begin
              if (step_q == 3'd3) begin
                ctl.reg_out_en  = 1'b1;
                ctl.mem_addr_en = 1'b1;
              end else if (step_q == 3'd4) begin
                ctl.dst_sel    = cpu_pkg::REG_RES;
                ctl.mem_out_en = 1'b1;
                ctl.reg_in_en  = 1'b1;
              end else if (step_q == 3'd5) begin
                ctl.src_sel    = cpu_pkg::REG_RES;
                ctl.alu_out_en = 1'b1;
                ctl.reg_in_en  = 1'b1;
              end
            end else begin
              ctl.alu_out_en = (step_q == 3'd3);
              ctl.reg_in_en  = (step_q == 3'd3);
            end
          end
          cpu_pkg::OP_JAL: begin
            ctl.ctl_data  = {8'h00, ir_q[7:0]};
            ctl.reg_in_en = 1'b1;
            case (step_q)
              3'd3: begin
                ctl.src_sel    = cpu_pkg::REG_PC;
                ctl.dst_sel    = cpu_pkg::REG_RA;
                ctl.reg_out_en = 1'b1;
              end
              3'd4: begin
                ctl.dst_sel    = cpu_pkg::REG_RES;
                ctl.ctl_out_en = 1'b1;  // Offset into RES
              end
              3'd5: begin
                ctl.src_sel    = funct;
                ctl.dst_sel    = cpu_pkg::REG_RES;
                ctl.alu_out_en = 1'b1;  // RES + reg[funct]
              end
              default: begin
                ctl.src_sel    = cpu_pkg::REG_RES;
                ctl.dst_sel    = cpu_pkg::REG_PC;
                ctl.reg_out_en = 1'b1;
              end
            endcase
          end
          cpu_pkg::OP_BR: begin
            if (step_q == 3'd3) begin
              ctl.alu_op     = cpu_pkg::ALU_SUB;
              ctl.alu_out_en = 1'b1;  // Flags only, nothing sinks the bus
            end else if (step_q == 3'd4 && br_taken) begin
              ctl.src_sel    = cpu_pkg::REG_BA;
              ctl.dst_sel    = cpu_pkg::REG_PC;
              ctl.reg_out_en = 1'b1;
              ctl.reg_in_en  = 1'b1;
            end
          end
          cpu_pkg::OP_STK: begin
            if (funct == 4'h0) begin  // PUSH
              ctl.src_sel     = (step_q == 3'd3) ? cpu_pkg::REG_SP : dst;
              ctl.reg_out_en  = (step_q == 3'd3) || (step_q == 3'd4);
              ctl.mem_addr_en = (step_q == 3'd3);
              ctl.mem_in_en   = (step_q == 3'd4);
              ctl.reg_sp_dec  = (step_q == 3'd5);
            end else if (funct == 4'h1) begin  // POP
              ctl.src_sel     = cpu_pkg::REG_SP;
              ctl.reg_sp_inc  = (step_q == 3'd3);
              ctl.reg_out_en  = (step_q == 3'd4);
              ctl.mem_addr_en = (step_q == 3'd4);
              ctl.mem_out_en  = (step_q == 3'd5);
              ctl.reg_in_en   = (step_q == 3'd5);
            end
          end
          default: begin
          end
        endcase
      end
    endcase
  end

  step_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    step_q <= cpu_pkg::LAST_STEP);

endmodule

// ==== design/cpu_ctrl_if.sv ====
interface cpu_ctrl_if;

  cpu_pkg::alu_op_t  alu_op;
  cpu_pkg::reg_sel_t src_sel;
  cpu_pkg::reg_sel_t dst_sel;
  logic              reg_out_en;
  logic              alu_out_en;
  logic              mem_out_en;
  logic              ctl_out_en;
  cpu_pkg::word_t    ctl_data;  // Immediate driven with ctl_out_en
  logic              mem_addr_en;
  logic              mem_in_en;
  logic              reg_in_en;
  logic              reg_lo_en;
  logic              reg_up_en;
  logic              dsp_in_en;
  logic              reg_pc_inc;
  logic              reg_sp_inc;
  logic              reg_sp_dec;

  modport ctrl (
    output alu_op, src_sel, dst_sel,
    output reg_out_en, alu_out_en, mem_out_en, ctl_out_en, ctl_data,
    output mem_addr_en, mem_in_en, reg_in_en, reg_lo_en, reg_up_en, dsp_in_en,
    output reg_pc_inc, reg_sp_inc, reg_sp_dec
  );

  modport dp (
    input alu_op, src_sel, dst_sel,
    input reg_out_en, alu_out_en, mem_out_en, ctl_out_en, ctl_data,
    input mem_addr_en, mem_in_en, reg_in_en, reg_lo_en, reg_up_en, dsp_in_en,
    input reg_pc_inc, reg_sp_inc, reg_sp_dec
  );

endinterface

// ==== design/cpu_pkg.sv ====
package cpu_pkg;

  typedef logic [15:0] word_t;
  typedef logic [3:0]  reg_sel_t;
  typedef logic [2:0]  step_t;
  typedef logic [3:0]  flags_t;  // {ovf, carry, neg, zero}

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SHL  = 4'd5,
    ALU_SHR  = 4'd6,
    ALU_PASS = 4'd7
  } alu_op_t;

  typedef enum logic [3:0] {
    OP_SYS  = 4'd0,
    OP_LLI  = 4'd1,
    OP_LUI  = 4'd2,
    OP_MEM  = 4'd3,
    OP_ALU0 = 4'd4,
    OP_ALU1 = 4'd5,
    OP_ALU2 = 4'd6,
    OP_ALU3 = 4'd7,
    OP_JAL  = 4'd8,
    OP_BR   = 4'd9,
    OP_STK  = 4'd10
  } opcode_t;

  localparam reg_sel_t REG_PC  = 4'd1;
  localparam reg_sel_t REG_SP  = 4'd2;
  localparam reg_sel_t REG_BA  = 4'd3;  // Branch target
  localparam reg_sel_t REG_RA  = 4'd4;  // Return address
  localparam reg_sel_t REG_RES = 4'd15;  // Scratch for microcode

  localparam step_t LAST_STEP = 3'd6;

endpackage
